// ==== byte_deserializer.sv ====
// bits arrive lsb first; alignment is fixed by the first valid bit after reset and never resyncs
module byte_deserializer (
   input  logic                clk,
   input  logic                reset,
   input  logic                bit_in,
   input  logic                bit_valid,
   output mpeg_sys_pkg::byte_t byte_data,
   output logic                byte_en
);
   logic [6:0] shift;   // first seven bits of the byte
   logic [2:0] cnt;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         cnt     <= '0;
         byte_en <= 1'b0;
      end
      else
      begin
         byte_en <= bit_valid && (cnt == 3'd7);
         if (bit_valid)
            cnt <= cnt + 3'd1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (bit_valid)
         shift <= {bit_in, shift[6:1]};
      if (bit_valid && (cnt == 3'd7))
         byte_data <= {bit_in, shift};   // first bit ends in bit 0
   end

endmodule

// ==== field_parse_if.sv ====
// one byte-stepped field task; no back-pressure, done is a single cycle pulse
interface field_parse_if;
   import mpeg_sys_pkg::*;

   byte_t byte_data;   // current stream byte
   logic  byte_en;     // new byte this cycle
   logic  active;      // worker owns the coming bytes
   logic  done;        // worker took its last byte

   modport ctrl (output byte_data, output byte_en, output active, input done);
   modport work (input byte_data, input byte_en, input active, output done);

endinterface

// ==== mpeg_sys_parser.f ====
mpeg_sys_pkg.sv
field_parse_if.sv
byte_deserializer.sv
start_code_detector.sv
stream_sequencer.sv
pack_header_parser.sv
system_header_parser.sv
time_stamp_decoder.sv
packet_parser.sv
mpeg_sys_parser.sv
tb_mpeg_sys_parser.sv

// ==== mpeg_sys_parser.sv ====
// serial system stream in, decoded fields out as valid strobes; no back-pressure on any output
module mpeg_sys_parser (
   input  logic                                   clk,
   input  logic                                   reset,
   input  logic                                   bit_in,
   input  logic                                   bit_valid,
   output logic                                   stream_end,
   output logic                                   pack_valid,
   output logic [mpeg_sys_pkg::SCR_BYTES*8-1:0]   scr_field,
   output logic [mpeg_sys_pkg::MUX_BYTES*8-1:0]   mux_rate_field,
   output logic                                   sys_valid,
   output logic [15:0]                            sys_len,
   output logic [mpeg_sys_pkg::RATE_BYTES*8-1:0]  rate_bound,
   output logic [mpeg_sys_pkg::FLAG_BYTES*8-1:0]  sys_flags,
   output mpeg_sys_pkg::byte_t                    stream_id,
   output logic                                   ts_valid,
   output mpeg_sys_pkg::ts_t                      pts,
   output mpeg_sys_pkg::ts_t                      dts,
   output logic                                   dts_present,
   output mpeg_sys_pkg::byte_t                    payload_data,
   output logic                                   payload_valid
);
   import mpeg_sys_pkg::*;

   byte_t      byte_data;
   byte_t      code_id;
   logic       byte_en;
   logic       code_valid;
   logic       hunt;
   logic [3:0] ts_len;

   field_parse_if pack_ps ();
   field_parse_if sys_ps ();
   field_parse_if pkt_ps ();
   field_parse_if ts_ps ();

   byte_deserializer u_deser (
      .clk(clk), .reset(reset), .bit_in(bit_in), .bit_valid(bit_valid),
      .byte_data(byte_data), .byte_en(byte_en)
   );

   start_code_detector u_detect (
      .clk(clk), .reset(reset), .byte_data(byte_data), .byte_en(byte_en),
      .hunt(hunt), .code_valid(code_valid), .code_id(code_id)
   );

   stream_sequencer u_seq (
      .clk(clk), .reset(reset), .byte_data(byte_data), .byte_en(byte_en),
      .code_valid(code_valid), .code_id(code_id), .hunt(hunt),
      .stream_id(stream_id), .stream_end(stream_end),
      .pack_ps(pack_ps.ctrl), .sys_ps(sys_ps.ctrl), .pkt_ps(pkt_ps.ctrl)
   );

   pack_header_parser u_pack (
      .clk(clk), .reset(reset), .ps(pack_ps.work),
      .scr_field(scr_field), .mux_rate_field(mux_rate_field), .pack_valid(pack_valid)
   );

   system_header_parser u_sys (
      .clk(clk), .reset(reset), .ps(sys_ps.work), .sys_len(sys_len),
      .rate_bound(rate_bound), .sys_flags(sys_flags), .sys_valid(sys_valid)
   );

   packet_parser u_pkt (
      .clk(clk), .reset(reset), .stream_id(stream_id), .ps(pkt_ps.work),
      .ts_ps(ts_ps.ctrl), .ts_done_len(ts_len),
      .payload_data(payload_data), .payload_valid(payload_valid)
   );

   time_stamp_decoder u_ts (
      .clk(clk), .reset(reset), .ps(ts_ps.work), .pts(pts), .dts(dts),
      .ts_valid(ts_valid), .dts_present(dts_present), .ts_len(ts_len)
   );

endmodule

// ==== mpeg_sys_pkg.sv ====
// shared by all parser blocks; bit order in a byte is the serial order with the first bit in bit 0
package mpeg_sys_pkg;

   typedef logic [7:0] byte_t;

   // code bytes after the 00 00 01 prefix
   localparam byte_t PACK_CODE     = 8'hBA;
   localparam byte_t SYS_CODE      = 8'hBB;
   localparam byte_t END_CODE      = 8'hB9;
   localparam byte_t PRIVATE2_ID   = 8'hBF;
   localparam byte_t PACKET_ID_MIN = 8'hBC;   // ids from here up are packets
   localparam byte_t STUFF_BYTE    = 8'hFF;
   localparam byte_t NO_TS_BYTE    = 8'h0F;

   localparam int SCR_BYTES       = 5;
   localparam int MUX_BYTES       = 3;
   localparam int RATE_BYTES      = 3;
   localparam int FLAG_BYTES      = 2;
   localparam int SYS_FIXED_BYTES = 6;         // rate bound, flags and reserved byte

   localparam int TS_W = 33;
   typedef logic [TS_W-1:0] ts_t;

   localparam logic [1:0] STD_PREFIX   = 2'b01;
   localparam logic [3:0] TS_KIND_PTS  = 4'b0010;
   localparam logic [3:0] TS_KIND_BOTH = 4'b0011;

   // sequencer states
   localparam logic [2:0] SEQ_HUNT = 3'd0;
   localparam logic [2:0] SEQ_PACK = 3'd1;
   localparam logic [2:0] SEQ_SYS  = 3'd2;
   localparam logic [2:0] SEQ_PKT  = 3'd3;
   localparam logic [2:0] SEQ_END  = 3'd4;

   // packet parser phases
   localparam logic [2:0] PKT_LEN_HI = 3'd0;
   localparam logic [2:0] PKT_LEN_LO = 3'd1;
   localparam logic [2:0] PKT_HDR    = 3'd2;   // stuffing or first header byte
   localparam logic [2:0] PKT_STD    = 3'd3;   // second STD byte
   localparam logic [2:0] PKT_TS     = 3'd4;
   localparam logic [2:0] PKT_DATA   = 3'd5;

   // first byte after stuffing, either an STD field or a time stamp lead
   typedef union packed {
      struct packed {
         logic [4:0] size;
         logic       scale;
         logic [1:0] prefix;
      } std_view;
      struct packed {
         logic       marker;
         logic [2:0] top;
         logic [3:0] kind;
      } ts_view;
   } pkt_hdr_byte_u;

endpackage

// ==== pack_header_parser.sv ====
// fields keep their marker bits; values change only when pack_valid pulses
module pack_header_parser (
   input  logic                                   clk,
   input  logic                                   reset,
   field_parse_if.work                            ps,
   output logic [mpeg_sys_pkg::SCR_BYTES*8-1:0]   scr_field,
   output logic [mpeg_sys_pkg::MUX_BYTES*8-1:0]   mux_rate_field,
   output logic                                   pack_valid
);
   import mpeg_sys_pkg::*;

   logic [2:0]                                cnt;
   logic [(SCR_BYTES + MUX_BYTES - 1)*8-1:0]  shift;   // all but the last byte

   assign pack_valid = ps.done;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         cnt     <= '0;
         ps.done <= 1'b0;
      end
      else
      begin
         ps.done <= 1'b0;
         if (!ps.active)
            cnt <= '0;
         else if (ps.byte_en)
         begin
            cnt <= cnt + 3'd1;
            if (cnt == 3'(SCR_BYTES + MUX_BYTES - 1))
               ps.done <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (ps.active && ps.byte_en)
      begin
         shift <= {shift[$bits(shift)-9:0], ps.byte_data};   // msb byte first
         if (cnt == 3'(SCR_BYTES + MUX_BYTES - 1))
            {scr_field, mux_rate_field} <= {shift, ps.byte_data};
      end
   end

endmodule

// ==== packet_parser.sv ====
// STD field is parsed and dropped; a packet with no payload ends one cycle after its last byte
module packet_parser (
   input  logic                clk,
   input  logic                reset,
   input  mpeg_sys_pkg::byte_t stream_id,
   field_parse_if.work         ps,
   field_parse_if.ctrl         ts_ps,
   input  logic [3:0]          ts_done_len,
   output mpeg_sys_pkg::byte_t payload_data,
   output logic                payload_valid
);
   import mpeg_sys_pkg::*;

   logic [2:0]    phase;
   logic [15:0]   remaining;   // bytes left after the length field
   byte_t         len_hi;
   pkt_hdr_byte_u hdr;
   logic          ts_lead;     // this byte starts the time stamp field

   assign hdr = ps.byte_data;
   assign ts_lead = (phase == PKT_HDR) && ps.byte_en && (ps.byte_data != STUFF_BYTE)
                    && (hdr.std_view.prefix != STD_PREFIX);

   assign ts_ps.byte_data = ps.byte_data;
   assign ts_ps.byte_en   = ps.byte_en;
   assign ts_ps.active    = ts_lead || (phase == PKT_TS);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         phase         <= PKT_LEN_HI;
         remaining     <= '0;
         ps.done       <= 1'b0;
         payload_valid <= 1'b0;
      end
      else
      begin
         ps.done       <= 1'b0;
         payload_valid <= 1'b0;
         if (!ps.active)
            phase <= PKT_LEN_HI;
         else if (phase == PKT_TS)
         begin
            if (ts_ps.done)
            begin
               remaining <= remaining - 16'(ts_done_len);
               phase     <= PKT_DATA;
               if (remaining == 16'(ts_done_len))
                  ps.done <= 1'b1;   // no payload
            end
         end
         else if (ps.byte_en)
         begin
            case (phase)
               PKT_LEN_HI: phase <= PKT_LEN_LO;
               PKT_LEN_LO:
               begin
                  remaining <= {len_hi, ps.byte_data};
                  phase     <= (stream_id == PRIVATE2_ID) ? PKT_DATA : PKT_HDR;
                  if ({len_hi, ps.byte_data} == 16'd0)
                     ps.done <= 1'b1;
               end
               PKT_HDR:
               begin
                  if (ts_lead)
                     phase <= PKT_TS;   // decoder counts the lead byte
                  else
                  begin
                     remaining <= remaining - 16'd1;
                     if (hdr.std_view.prefix == STD_PREFIX)
                        phase <= PKT_STD;
                  end
               end
               PKT_STD:
               begin
                  remaining <= remaining - 16'd1;
                  phase     <= PKT_HDR;
               end
               PKT_DATA:
               begin
                  payload_valid <= 1'b1;
                  remaining     <= remaining - 16'd1;
                  if (remaining == 16'd1)
                     ps.done <= 1'b1;
               end
               default: phase <= PKT_LEN_HI;
            endcase
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (ps.active && ps.byte_en)
      begin
         if (phase == PKT_LEN_HI)
            len_hi <= ps.byte_data;
         if (phase == PKT_DATA)
            payload_data <= ps.byte_data;
      end
   end

endmodule

// ==== start_code_detector.sv ====
// matches only while hunt is high; two or more zero bytes followed by 01 count as a prefix
module start_code_detector (
   input  logic                clk,
   input  logic                reset,
   input  mpeg_sys_pkg::byte_t byte_data,
   input  logic                byte_en,
   input  logic                hunt,
   output logic                code_valid,
   output mpeg_sys_pkg::byte_t code_id
);
   logic [1:0] zeros;        // zero bytes seen, stops at 2
   logic       prefix_seen;  // next byte is the code

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         zeros       <= '0;
         prefix_seen <= 1'b0;
         code_valid  <= 1'b0;
      end
      else
      begin
         code_valid <= 1'b0;
         if (!hunt)
         begin
            zeros       <= '0;
            prefix_seen <= 1'b0;
         end
         else if (byte_en)
         begin
            if (prefix_seen)
            begin
               code_valid  <= 1'b1;
               prefix_seen <= 1'b0;
               zeros       <= '0;
            end
            else if (byte_data == 8'h00)
            begin
               if (zeros != 2'd2)
                  zeros <= zeros + 2'd1;
            end
            else
            begin
               prefix_seen <= (zeros == 2'd2) && (byte_data == 8'h01);
               zeros       <= '0;
            end
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (hunt && byte_en && prefix_seen)
         code_id <= byte_data;
   end

endmodule

// ==== stream_sequencer.sv ====
// one worker at a time; codes other than pack, system, end and packet ids are skipped
module stream_sequencer (
   input  logic                clk,
   input  logic                reset,
   input  mpeg_sys_pkg::byte_t byte_data,
   input  logic                byte_en,
   input  logic                code_valid,
   input  mpeg_sys_pkg::byte_t code_id,
   output logic                hunt,
   output mpeg_sys_pkg::byte_t stream_id,
   output logic                stream_end,
   field_parse_if.ctrl         pack_ps,
   field_parse_if.ctrl         sys_ps,
   field_parse_if.ctrl         pkt_ps
);
   import mpeg_sys_pkg::*;

   logic [2:0] state;

   assign hunt       = (state == SEQ_HUNT);
   assign stream_end = (state == SEQ_END);   // held until reset

   assign pack_ps.byte_data = byte_data;
   assign pack_ps.byte_en   = byte_en;
   assign pack_ps.active    = (state == SEQ_PACK);
   assign sys_ps.byte_data  = byte_data;
   assign sys_ps.byte_en    = byte_en;
   assign sys_ps.active     = (state == SEQ_SYS);
   assign pkt_ps.byte_data  = byte_data;
   assign pkt_ps.byte_en    = byte_en;
   assign pkt_ps.active     = (state == SEQ_PKT);

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= SEQ_HUNT;
      else
      begin
         case (state)
            SEQ_HUNT:
               if (code_valid)
               begin
                  if (code_id == PACK_CODE)
                     state <= SEQ_PACK;
                  else if (code_id == SYS_CODE)
                     state <= SEQ_SYS;
                  else if (code_id == END_CODE)
                     state <= SEQ_END;
                  else if (code_id >= PACKET_ID_MIN)
                     state <= SEQ_PKT;
               end
            SEQ_PACK: if (pack_ps.done) state <= SEQ_HUNT;
            SEQ_SYS:  if (sys_ps.done) state <= SEQ_HUNT;
            SEQ_PKT:  if (pkt_ps.done) state <= SEQ_HUNT;
            default:  state <= state;   // ended
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (hunt && code_valid && (code_id >= PACKET_ID_MIN))
         stream_id <= code_id;
   end

endmodule

// ==== system_header_parser.sv ====
// stream bound table and reserved byte are skipped by count; a length below 5 is not handled
module system_header_parser (
   input  logic                                   clk,
   input  logic                                   reset,
   field_parse_if.work                            ps,
   output logic [15:0]                            sys_len,
   output logic [mpeg_sys_pkg::RATE_BYTES*8-1:0]  rate_bound,
   output logic [mpeg_sys_pkg::FLAG_BYTES*8-1:0]  sys_flags,
   output logic                                   sys_valid
);
   import mpeg_sys_pkg::*;

   logic [2:0]                                 idx;       // fixed byte index
   logic                                       skipping;
   logic [15:0]                                left;      // bytes still to skip
   logic [(1 + RATE_BYTES + FLAG_BYTES)*8-1:0] shift;
   logic [15:0]                                skip_len;

   // table bytes plus the reserved byte
   assign skip_len = shift[$bits(shift)-1 -: 16] - 16'(SYS_FIXED_BYTES - 1);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         idx       <= '0;
         skipping  <= 1'b0;
         left      <= '0;
         ps.done   <= 1'b0;
         sys_valid <= 1'b0;
      end
      else
      begin
         ps.done   <= 1'b0;
         sys_valid <= 1'b0;
         if (!ps.active)
         begin
            idx      <= '0;
            skipping <= 1'b0;
         end
         else if (ps.byte_en)
         begin
            if (skipping)
            begin
               left <= left - 16'd1;
               if (left == 16'd1)
                  ps.done <= 1'b1;
            end
            else if (idx == 3'(1 + RATE_BYTES + FLAG_BYTES))
            begin
               sys_valid <= 1'b1;   // flag word complete
               skipping  <= 1'b1;
               left      <= skip_len;
               if (skip_len == 16'd0)
                  ps.done <= 1'b1;
            end
            else
               idx <= idx + 3'd1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (ps.active && ps.byte_en && !skipping)
      begin
         shift <= {shift[$bits(shift)-9:0], ps.byte_data};
         if (idx == 3'(1 + RATE_BYTES + FLAG_BYTES))
            {sys_len, rate_bound, sys_flags} <= {shift, ps.byte_data};
      end
   end

endmodule

// ==== tb_mpeg_sys_parser.sv ====
// bit_valid gaps and payload bytes come from one fixed seed; dts is not checked without dts_present
module tb_mpeg_sys_parser;
   timeunit 1ns;
   timeprecision 100ps;
   import mpeg_sys_pkg::*;

   logic        clk;
   logic        reset;
   logic        bit_in;
   logic        bit_valid;
   logic        stream_end;
   logic        pack_valid;
   logic [39:0] scr_field;
   logic [23:0] mux_rate_field;
   logic        sys_valid;
   logic [15:0] sys_len;
   logic [23:0] rate_bound;
   logic [15:0] sys_flags;
   byte_t       stream_id;
   logic        ts_valid;
   ts_t         pts;
   ts_t         dts;
   logic        dts_present;
   byte_t       payload_data;
   logic        payload_valid;

   byte_t       stream_q[$];   // whole stream in send order
   logic [39:0] exp_scr[0:3];
   logic [23:0] exp_mux[0:3];
   logic [15:0] exp_sys_len;
   logic [23:0] exp_rate;
   logic [15:0] exp_flags;
   ts_t         exp_pts[0:3];
   ts_t         exp_dts[0:3];
   logic        exp_dtsp[0:3];
   byte_t       exp_pay[0:63];
   byte_t       exp_pay_id[0:63];
   int          n_pack;
   int          n_sys;
   int          n_ts;
   int          n_pay;
   int          pack_cnt;
   int          sys_cnt;
   int          ts_cnt;
   int          pay_cnt;
   int          bytes_sent;
   int          quiet_bytes;   // bytes up to and including the first code
   int          end_pos;
   int          cycles;
   int          cycle_limit;
   int          value_errs;
   int          event_errs;
   integer      seed;

   mpeg_sys_parser dut_i (
      .clk(clk), .reset(reset), .bit_in(bit_in), .bit_valid(bit_valid),
      .stream_end(stream_end), .pack_valid(pack_valid), .scr_field(scr_field),
      .mux_rate_field(mux_rate_field), .sys_valid(sys_valid), .sys_len(sys_len),
      .rate_bound(rate_bound), .sys_flags(sys_flags), .stream_id(stream_id),
      .ts_valid(ts_valid), .pts(pts), .dts(dts), .dts_present(dts_present),
      .payload_data(payload_data), .payload_valid(payload_valid)
   );

   always #10 clk = ~clk;

   task automatic value_mismatch(input string sig, input logic [63:0] got,
                                 input logic [63:0] want);
      value_errs++;
      $display("Fail at %0t ns: %s got %h expected %h", $time, sig, got, want);
   endtask

   task automatic event_error(input string what);
      event_errs++;
      $display("Error at %0t ns: %s", $time, what);
   endtask

   task automatic print_counts();
      $display("errors: %0d wrong values, %0d other failures", value_errs, event_errs);
   endtask

   // lead kind in the low nibble and markers in bit 7 of bytes 0, 2 and 4
   function automatic logic [39:0] ts_bytes(input logic [3:0] kind, input ts_t v);
      ts_bytes = {1'b1, v[32:30], kind, v[29:22], 1'b1, v[21:15], v[14:7], 1'b1, v[6:0]};
   endfunction

   task automatic put(input byte_t b);
      stream_q.push_back(b);
   endtask

   task automatic put_code(input byte_t code);
      put(8'h00);
      put(8'h00);
      put(8'h01);
      put(code);
   endtask

   task automatic add_pack(input logic [39:0] scr, input logic [23:0] mux, input bit counted);
      logic [63:0] bytes;
      int i;
      bytes = {scr, mux};
      put_code(PACK_CODE);
      for (i = 7; i >= 0; i--)
         put(bytes[i*8 +: 8]);
      if (counted)
      begin
         exp_scr[n_pack] = scr;
         exp_mux[n_pack] = mux;
         n_pack++;
      end
   endtask

   task automatic add_sys(input logic [23:0] rate, input logic [15:0] flags, input int n_entries);
      logic [15:0] len;
      int i;
      len = 16'(SYS_FIXED_BYTES + 3 * n_entries);
      put_code(SYS_CODE);
      put(len[15:8]);
      put(len[7:0]);
      for (i = 2; i >= 0; i--)
         put(rate[i*8 +: 8]);
      put(flags[15:8]);
      put(flags[7:0]);
      put(8'hFF);   // reserved byte
      for (i = 0; i < n_entries; i++)
      begin
         put(8'hC0 + 8'(i));   // stream table entry
         put(8'hE0);
         put(8'h20);
      end
      exp_sys_len = len;
      exp_rate    = rate;
      exp_flags   = flags;
      n_sys++;
   endtask

   // ts_mode 0 gives NO_TS_BYTE, 1 PTS only, 2 PTS and DTS
   task automatic add_packet(input byte_t id, input int n_stuff, input bit has_std,
                             input int ts_mode, input ts_t p, input ts_t d,
                             input int n_data, input bit embed);
      byte_t       hdr[$];
      byte_t       data[$];
      logic [39:0] tsb;
      logic [15:0] len;
      logic [31:0] fake;
      int i;
      fake = {8'h00, 8'h00, 8'h01, PACK_CODE};   // looks like a start code in payload
      if (id != PRIVATE2_ID)
      begin
         for (i = 0; i < n_stuff; i++)
            hdr.push_back(STUFF_BYTE);
         if (has_std)
         begin
            hdr.push_back(8'h45);   // prefix 01 with scale and size bits
            hdr.push_back(8'h80);
         end
         if (ts_mode == 0)
            hdr.push_back(NO_TS_BYTE);
         else
         begin
            tsb = ts_bytes((ts_mode == 2) ? 4'b0011 : 4'b0010, p);
            for (i = 4; i >= 0; i--)
               hdr.push_back(tsb[i*8 +: 8]);
            if (ts_mode == 2)
            begin
               tsb = ts_bytes(4'b0001, d);
               for (i = 4; i >= 0; i--)
                  hdr.push_back(tsb[i*8 +: 8]);
            end
            exp_pts[n_ts]  = p;
            exp_dts[n_ts]  = d;
            exp_dtsp[n_ts] = (ts_mode == 2);
            n_ts++;
         end
      end
      for (i = 0; i < n_data; i++)
      begin
         if (embed && (i >= 2) && (i <= 5))
            data.push_back(fake[(5 - i)*8 +: 8]);
         else
            data.push_back(byte_t'($random(seed)));
         exp_pay[n_pay]    = data[i];
         exp_pay_id[n_pay] = id;
         n_pay++;
      end
      len = 16'(hdr.size() + data.size());
      put_code(id);
      put(len[15:8]);
      put(len[7:0]);
      foreach (hdr[j])
         put(hdr[j]);
      foreach (data[j])
         put(data[j]);
   endtask

   task automatic build_stream();
      put(8'h47);   // garbage whose lone zero before 01 must not start a code
      put(8'h00);
      put(8'h01);
      put(END_CODE);
      quiet_bytes = stream_q.size() + 4;
      add_pack(40'h21_0001_8003, 24'h80_1F41, 1'b1);
      add_sys(24'h80_3E81, 16'hE5FF, 2);
      add_pack(40'h31_2345_6789, 24'h80_2EE1, 1'b1);
      add_packet(8'hE0, 2, 1'b1, 2, 33'h1_2345_6789, 33'h0_ABCD_EF01, 12, 1'b1);
      add_packet(PRIVATE2_ID, 0, 1'b0, 0, '0, '0, 6, 1'b0);
      add_packet(8'hC0, 1, 1'b0, 0, '0, '0, 5, 1'b0);
      add_packet(8'hC1, 0, 1'b1, 1, 33'h0_0000_1234, '0, 4, 1'b0);
      put_code(END_CODE);
      end_pos = stream_q.size();
      add_pack(40'h21_FFFF_FFFF, 24'h81_0001, 1'b0);   // after the end code
   endtask

   // lsb first with random idle cycles between bits
   task automatic send_byte(input byte_t b);
      int i;
      i = 0;
      while (i < 8)
      begin
         @(posedge clk);
         #1;
         if (($random(seed) & 3) == 0)
            bit_valid = 1'b0;
         else
         begin
            bit_in    = b[i];
            bit_valid = 1'b1;
            i++;
         end
      end
   endtask

   always @(posedge clk)
   begin
      if (reset)
      begin
         pack_cnt <= 0;
         sys_cnt  <= 0;
         ts_cnt   <= 0;
         pay_cnt  <= 0;
      end
      else
      begin
         if (pack_valid)
            pack_cnt <= pack_cnt + 1;
         if (sys_valid)
            sys_cnt <= sys_cnt + 1;
         if (ts_valid)
            ts_cnt <= ts_cnt + 1;
         if (payload_valid)
            pay_cnt <= pay_cnt + 1;
      end
   end

   quiet_start: assert property (@(posedge clk) disable iff (reset)
      (bytes_sent < quiet_bytes) |->
         !(pack_valid || sys_valid || ts_valid || payload_valid || stream_end))
      else event_error("strobe seen before the first start code was complete");
   pack_count: assert property (@(posedge clk) disable iff (reset)
      pack_valid |-> pack_cnt < n_pack)
      else event_error("pack_valid without an expected pack header");
   pack_scr: assert property (@(posedge clk) disable iff (reset)
      pack_valid && pack_cnt < n_pack |-> scr_field == exp_scr[pack_cnt])
      else value_mismatch("scr_field", $sampled(scr_field), $sampled(exp_scr[pack_cnt]));
   pack_mux: assert property (@(posedge clk) disable iff (reset)
      pack_valid && pack_cnt < n_pack |-> mux_rate_field == exp_mux[pack_cnt])
      else value_mismatch("mux_rate_field", $sampled(mux_rate_field),
                          $sampled(exp_mux[pack_cnt]));
   sys_count: assert property (@(posedge clk) disable iff (reset)
      sys_valid |-> sys_cnt < n_sys)
      else event_error("sys_valid without an expected system header");
   sys_fields: assert property (@(posedge clk) disable iff (reset)
      sys_valid |-> {sys_len, rate_bound, sys_flags} == {exp_sys_len, exp_rate, exp_flags})
      else value_mismatch("sys_len/rate_bound/sys_flags",
                          $sampled({sys_len, rate_bound, sys_flags}),
                          $sampled({exp_sys_len, exp_rate, exp_flags}));
   ts_count: assert property (@(posedge clk) disable iff (reset)
      ts_valid |-> ts_cnt < n_ts)
      else event_error("ts_valid on a packet without PTS");
   ts_pts: assert property (@(posedge clk) disable iff (reset)
      ts_valid && ts_cnt < n_ts |-> pts == exp_pts[ts_cnt])
      else value_mismatch("pts", $sampled(pts), $sampled(exp_pts[ts_cnt]));
   ts_dtsp: assert property (@(posedge clk) disable iff (reset)
      ts_valid && ts_cnt < n_ts |-> dts_present == exp_dtsp[ts_cnt])
      else value_mismatch("dts_present", $sampled(dts_present), $sampled(exp_dtsp[ts_cnt]));
   ts_dts: assert property (@(posedge clk) disable iff (reset)
      ts_valid && ts_cnt < n_ts && exp_dtsp[ts_cnt] |-> dts == exp_dts[ts_cnt])
      else value_mismatch("dts", $sampled(dts), $sampled(exp_dts[ts_cnt]));
   pay_count: assert property (@(posedge clk) disable iff (reset)
      payload_valid |-> pay_cnt < n_pay)
      else event_error("more payload bytes than were sent");
   pay_data: assert property (@(posedge clk) disable iff (reset)
      payload_valid && pay_cnt < n_pay |-> payload_data == exp_pay[pay_cnt])
      else value_mismatch("payload_data", $sampled(payload_data), $sampled(exp_pay[pay_cnt]));
   pay_id: assert property (@(posedge clk) disable iff (reset)
      payload_valid && pay_cnt < n_pay |-> stream_id == exp_pay_id[pay_cnt])
      else value_mismatch("stream_id", $sampled(stream_id), $sampled(exp_pay_id[pay_cnt]));
   end_hold: assert property (@(posedge clk) disable iff (reset)
      stream_end |=> stream_end)
      else event_error("stream_end dropped after the end code");
   end_early: assert property (@(posedge clk) disable iff (reset)
      stream_end |-> bytes_sent >= end_pos)
      else event_error("stream_end raised before the end code was sent");

   // run limit from the stream length
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if ((cycle_limit > 0) && (cycles >= cycle_limit))
      begin
         event_error("run reached the cycle limit before the stream was done");
         print_counts();
         $display("TEST FAILED");
         $finish;
      end
   end

   initial
   begin
      clk         = 1'b0;
      reset       = 1'b1;
      bit_in      = 1'b0;
      bit_valid   = 1'b0;
      seed        = 53;
      n_pack      = 0;
      n_sys       = 0;
      n_ts        = 0;
      n_pay       = 0;
      bytes_sent  = 0;
      cycles      = 0;
      cycle_limit = 0;
      value_errs  = 0;
      event_errs  = 0;
      build_stream();
      cycle_limit = stream_q.size() * 8 * 4 + 200;
      repeat (4) @(posedge clk);
      #1 reset = 1'b0;
      foreach (stream_q[k])
      begin
         send_byte(stream_q[k]);
         bytes_sent++;
      end
      @(posedge clk);
      #1 bit_valid = 1'b0;
      wait (stream_end === 1'b1);
      repeat (8) @(posedge clk);   // room for a stray pack_valid
      assert (pack_cnt == n_pack) else value_mismatch("pack_valid count", pack_cnt, n_pack);
      assert (sys_cnt == n_sys) else value_mismatch("sys_valid count", sys_cnt, n_sys);
      assert (ts_cnt == n_ts) else value_mismatch("ts_valid count", ts_cnt, n_ts);
      assert (pay_cnt == n_pay) else value_mismatch("payload_valid count", pay_cnt, n_pay);
      print_counts();
      if (value_errs + event_errs == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== time_stamp_decoder.sv ====
// lead bytes that are neither PTS nor PTS+DTS count as a single NO_TS_BYTE; markers are not checked
module time_stamp_decoder (
   input  logic              clk,
   input  logic              reset,
   field_parse_if.work       ps,
   output mpeg_sys_pkg::ts_t pts,
   output mpeg_sys_pkg::ts_t dts,
   output logic              ts_valid,
   output logic              dts_present,
   output logic [3:0]        ts_len
);
   import mpeg_sys_pkg::*;

   pkt_hdr_byte_u lead;
   logic [3:0]    pos;        // byte index in the field
   logic          two_ts;     // dts follows pts
   ts_t           acc;        // value being assembled
   ts_t           pts_hold;
   ts_t           word;       // value the current byte completes

   assign lead = ps.byte_data;
   assign word = {acc[TS_W-1:7], ps.byte_data[6:0]};

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         pos         <= '0;
         two_ts      <= 1'b0;
         ps.done     <= 1'b0;
         ts_valid    <= 1'b0;
         dts_present <= 1'b0;
      end
      else
      begin
         ps.done  <= 1'b0;
         ts_valid <= 1'b0;
         if (!ps.active)
            pos <= '0;
         else if (ps.byte_en)
         begin
            pos <= pos + 4'd1;
            case (pos)
               4'd0:
                  if (lead.ts_view.kind inside {TS_KIND_PTS, TS_KIND_BOTH})
                     two_ts <= (lead.ts_view.kind == TS_KIND_BOTH);
                  else
                     ps.done <= 1'b1;   // no time stamp
               4'd4:
                  if (!two_ts)
                  begin
                     ps.done     <= 1'b1;
                     ts_valid    <= 1'b1;
                     dts_present <= 1'b0;
                  end
               4'd9:
               begin
                  ps.done     <= 1'b1;
                  ts_valid    <= 1'b1;
                  dts_present <= 1'b1;
               end
               default: two_ts <= two_ts;
            endcase
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (ps.active && ps.byte_en)
      begin
         ts_len <= pos + 4'd1;   // bytes taken so far
         case (pos)
            4'd0, 4'd5: acc[32:30] <= lead.ts_view.top;
            4'd1, 4'd6: acc[29:22] <= ps.byte_data;
            4'd2, 4'd7: acc[21:15] <= ps.byte_data[6:0];
            4'd3, 4'd8: acc[14:7]  <= ps.byte_data;
            4'd4:
            begin
               pts_hold <= word;
               if (!two_ts)
                  pts <= word;
            end
            4'd9:
            begin
               pts <= pts_hold;
               dts <= word;
            end
            default: acc <= acc;
         endcase
      end
   end

endmodule
